// ==== bench/rollout_checker.sv ====
// Rollout reference model and checker

`timescale 1ns/100ps
`default_nettype none
`include "rollout_consts.svh"

module rollout_checker (
    input  logic                                                 clk,
    input  logic                                                 rst,
    input  logic                                                 start,
    input  rollout_num_pkg::step_t                               active_horizon,
    input  rollout_num_pkg::data_t [`STATE_DIM-1:0]              x_init,
    input  rollout_num_pkg::data_t [`STATE_DIM*`STATE_DIM-1:0]   a_mem,
    input  rollout_num_pkg::data_t [`STATE_DIM*`INPUT_DIM-1:0]   b_mem,
    input  rollout_num_pkg::data_t [`INPUT_DIM*`STATE_DIM-1:0]   k_mem,
    input  rollout_num_pkg::data_t [`HORIZON_MAX*`INPUT_DIM-1:0] d_mem,
    input  rollout_bus_pkg::coef_req_t                           coef_rd,
    input  rollout_bus_pkg::rd_req_t                             d_rd,
    input  rollout_bus_pkg::wr_port_t                            x_wr,
    input  rollout_bus_pkg::wr_port_t                            u_wr,
    input  logic                                                 done,
    output int                                                   errors,
    output int                                                   checks
);
    import rollout_num_pkg::*;
    import rollout_bus_pkg::*;

    localparam int NX = `STATE_DIM;
    localparam int NU = `INPUT_DIM;
    localparam int XW = `HORIZON_MAX * NX;
    localparam int UW = `HORIZON_MAX * NU;

    data_t x_ref [XW];
    data_t u_ref [UW];
    int    x_hits [XW];
    int    u_hits [UW];
    // Request counts per matrix, indexed by coef_sel_t
    int    coef_hits [3][NX*NX];
    int    run_no;
    int    horizon;
    int    x_count;
    int    u_count;
    bit    start_q;
    bit    done_q;
    bit    writes_seen;

    task automatic value_error(input string name, input data_t exp, input data_t act);
        errors++;
        $display("** Error %s: expected %h, actual %h (time %0t)", name, exp, act, $time);
    endtask

    task automatic protocol_error(input string what);
        errors++;
        $display("Check failed at %0t, %s", $time, what);
    endtask

    function automatic int matrix_words(input int sel);
        return (sel == 0) ? NX*NX : NX*NU;
    endfunction

    // u[k] = -K x[k] - d[k], x[k+1] = A x[k] + B u[k], wrapping to data_t
    task automatic build_model();
        data_t xv [NX];
        data_t xn [NX];
        data_t uv [NU];
        data_t acc;
        horizon = int'(active_horizon);
        for (int i = 0; i < NX; i++)
            xv[i] = x_init[i];
        for (int k = 0; k < horizon; k++) begin
            for (int i = 0; i < NU; i++) begin
                acc = '0;
                for (int j = 0; j < NX; j++)
                    acc = acc + k_mem[i*NX+j] * xv[j];
                uv[i] = -acc - d_mem[k*NU+i];
                u_ref[k*NU+i] = uv[i];
            end
            for (int r = 0; r < NX; r++) begin
                acc = '0;
                for (int c = 0; c < NX; c++)
                    acc = acc + a_mem[r*NX+c] * xv[c];
                for (int c = 0; c < NU; c++)
                    acc = acc + b_mem[r*NU+c] * uv[c];
                xn[r] = acc;
                x_ref[k*NX+r] = xv[r];
            end
            xv = xn;
        end
        x_hits = '{default: 0};
        u_hits = '{default: 0};
        coef_hits = '{default: 0};
        x_count = 0;
        u_count = 0;
        writes_seen = 1'b0;
    endtask

    task automatic count_request();
        int sel;
        sel = int'(coef_rd.sel);
        checks++;
        if (writes_seen) begin
            protocol_error("coefficient read after the first write");
        end else if (sel > 2 || int'(coef_rd.addr) >= matrix_words(sel)) begin
            protocol_error("coefficient read outside the matrices");
        end else begin
            coef_hits[sel][coef_rd.addr]++;
        end
    endtask

    task automatic verify_coef_reads();
        for (int s = 0; s < 3; s++) begin
            for (int a = 0; a < matrix_words(s); a++) begin
                checks++;
                if (coef_hits[s][a] != 1)
                    protocol_error($sformatf("run %0d matrix %0d word %0d was read %0d times",
                                             run_no, s, a, coef_hits[s][a]));
            end
        end
    endtask

    task automatic check_write(input bit is_x, input wr_port_t wr);
        int    idx;
        int    w;
        string name;
        data_t exp;
        idx = int'(wr.addr);
        w = is_x ? NX : NU;
        name = $sformatf("run %0d %s[%0d][%0d]", run_no, is_x ? "x" : "u", idx / w, idx % w);
        checks++;
        if (is_x)
            x_count++;
        else
            u_count++;
        if (idx >= horizon * w) begin
            protocol_error({name, " was written outside the horizon"});
        end else begin
            exp = is_x ? x_ref[idx] : u_ref[idx];
            if ((is_x ? x_hits[idx] : u_hits[idx]) != 0)
                protocol_error({name, " was written twice"});
            else if (wr.data !== exp)
                value_error(name, exp, wr.data);
            if (is_x)
                x_hits[idx]++;
            else
                u_hits[idx]++;
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            start_q = 1'b0;
            done_q  = 1'b0;
        end else begin
            if (start && !start_q) begin
                run_no++;
                build_model();
            end
            checks++;
            if (!start && (coef_rd.valid || d_rd.valid || x_wr.wren || u_wr.wren))
                protocol_error("bus activity while start is low");
            if (!start_q && done)
                protocol_error("done high while start is low");
            if (start && done_q && !done)
                protocol_error("done fell while start was still high");
            if (coef_rd.valid)
                count_request();
            if (start && d_rd.valid && int'(d_rd.addr) >= horizon * NU)
                protocol_error($sformatf("run %0d d read at address %0d outside the horizon",
                                         run_no, d_rd.addr));
            // All coefficients must be fetched before the first write
            if ((x_wr.wren || u_wr.wren) && !writes_seen) begin
                verify_coef_reads();
                writes_seen = 1'b1;
            end
            if (done_q && (x_wr.wren || u_wr.wren))
                protocol_error("write after done");
            if (x_wr.wren)
                check_write(1'b1, x_wr);
            if (u_wr.wren)
                check_write(1'b0, u_wr);
            if (done && !done_q) begin
                checks++;
                if (x_count != horizon * NX || u_count != horizon * NU)
                    protocol_error($sformatf("run %0d wrote %0d x and %0d u words, not %0d and %0d",
                                             run_no, x_count, u_count, horizon * NX, horizon * NU));
            end
            start_q = start;
            done_q  = done;
        end
    end

endmodule

`default_nettype wire

// ==== bench/rollout_tb.sv ====
// Rollout testbench

`timescale 1ns/100ps
`default_nettype none
`include "rollout_consts.svh"

module rollout_tb;
    import rollout_num_pkg::*;
    import rollout_bus_pkg::*;

    localparam int NX   = `STATE_DIM;
    localparam int NU   = `INPUT_DIM;
    localparam int RUNS = 8;

    logic                        clk;
    logic                        rst;
    logic                        start;
    step_t                       active_horizon;
    data_t [NX-1:0]              x_init;
    data_t                       coef_data;
    data_t                       d_data;
    coef_req_t                   coef_rd;
    rd_req_t                     d_rd;
    wr_port_t                    x_wr;
    wr_port_t                    u_wr;
    logic                        done;

    // Memory contents behind the read ports
    data_t [NX*NX-1:0]           a_mem;
    data_t [NX*NU-1:0]           b_mem;
    data_t [NU*NX-1:0]           k_mem;
    data_t [`HORIZON_MAX*NU-1:0] d_mem;

    step_t horizons [RUNS];
    int    total_cycles;
    int    limit_cycles;
    int    seed_ret;
    int    errors;
    int    checks;

    rollout_top rollout_top_i (
        .clk            (clk),
        .rst            (rst),
        .start          (start),
        .active_horizon (active_horizon),
        .x_init         (x_init),
        .coef_rd        (coef_rd),
        .coef_data      (coef_data),
        .d_rd           (d_rd),
        .d_data         (d_data),
        .x_wr           (x_wr),
        .u_wr           (u_wr),
        .done           (done)
    );

    rollout_checker checker_i (
        .clk            (clk),
        .rst            (rst),
        .start          (start),
        .active_horizon (active_horizon),
        .x_init         (x_init),
        .a_mem          (a_mem),
        .b_mem          (b_mem),
        .k_mem          (k_mem),
        .d_mem          (d_mem),
        .coef_rd        (coef_rd),
        .d_rd           (d_rd),
        .x_wr           (x_wr),
        .u_wr           (u_wr),
        .done           (done),
        .errors         (errors),
        .checks         (checks)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    function automatic data_t coef_word(input coef_req_t req);
        data_t word;
        // Out-of-range reads return a marker that carries the address
        word = 32'hbad0_0000 ^ data_t'(req.addr);
        case (req.sel)
            coef_a: if (req.addr < NX*NX) word = a_mem[req.addr];
            coef_b: if (req.addr < NX*NU) word = b_mem[req.addr];
            coef_k: if (req.addr < NU*NX) word = k_mem[req.addr];
            default: ;
        endcase
        return word;
    endfunction

    // Both read ports return the word one cycle after the request
    always @(posedge clk) begin : read_ports
        coef_req_t creq;
        rd_req_t   dreq;
        creq = coef_rd;
        dreq = d_rd;
        #10;
        if (creq.valid) begin
            coef_data = coef_word(creq);
        end
        if (dreq.valid && (dreq.addr < `HORIZON_MAX*NU)) begin
            d_data = d_mem[dreq.addr];
        end
    end

    task automatic load_run(input int run);
        for (int i = 0; i < NX*NX; i++)
            a_mem[i] = $urandom;
        for (int i = 0; i < NX*NU; i++) begin
            b_mem[i] = $urandom;
            k_mem[i] = $urandom;
        end
        for (int i = 0; i < `HORIZON_MAX*NU; i++)
            d_mem[i] = $urandom;
        for (int i = 0; i < NX; i++)
            x_init[i] = $urandom;
        active_horizon = horizons[run];
    endtask

    // Watchdog, armed once the run lengths are known
    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("Timeout after %0d cycles, the DUT never finished its runs", limit_cycles);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        seed_ret = $urandom(32'h72b8_89d2);
        rst = 1'b1;
        start = 1'b0;
        active_horizon = step_t'(1);
        x_init = '0;
        coef_data = '0;
        d_data = '0;
        a_mem = '0;
        b_mem = '0;
        k_mem = '0;
        d_mem = '0;
        limit_cycles = 0;
        for (int r = 0; r < RUNS; r++)
            horizons[r] = step_t'(1 + $urandom % `HORIZON_MAX);
        // Shortest and longest horizons are always covered
        horizons[0] = step_t'(1);
        horizons[3] = step_t'(`HORIZON_MAX);
        total_cycles = 0;
        for (int r = 0; r < RUNS; r++)
            total_cycles += 60 + int'(horizons[r]) * 80;
        limit_cycles = total_cycles + total_cycles / 5;

        repeat (2) @(posedge clk);
        #10 rst = 1'b0;
        for (int run = 0; run < RUNS; run++) begin
            @(posedge clk);
            #10;
            load_run(run);
            start = 1'b1;
            do begin
                @(posedge clk);
            end while (!done);
            #10 start = 1'b0;
            do begin
                @(posedge clk);
            end while (done);
        end
        repeat (2) @(posedge clk);

        $display("Runs: %0d, checks: %0d, errors: %0d", RUNS, checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+hw
hw/rollout_num_pkg.sv
hw/rollout_bus_pkg.sv
hw/coef_loader.sv
hw/control_law.sv
hw/state_update.sv
hw/trajectory_writer.sv
hw/rollout_top.sv
bench/rollout_checker.sv
bench/rollout_tb.sv

// ==== hw/coef_loader.sv ====
// Coefficient loader and run control

`timescale 1ns/100ps
`default_nettype none
`include "rollout_consts.svh"

module coef_loader (
    input  logic                                               clk,
    input  logic                                               rst,
    input  logic                                               start,
    output rollout_bus_pkg::coef_req_t                         coef_rd,
    input  rollout_num_pkg::data_t                             coef_data,
    output rollout_num_pkg::data_t [`STATE_DIM*`STATE_DIM-1:0] a_bank,
    output rollout_num_pkg::data_t [`STATE_DIM*`INPUT_DIM-1:0] b_bank,
    output rollout_num_pkg::data_t [`INPUT_DIM*`STATE_DIM-1:0] k_bank,
    output logic                                               run_go
);
    import rollout_num_pkg::*;
    import rollout_bus_pkg::*;

    localparam int NA = `STATE_DIM * `STATE_DIM;
    localparam int NB = `STATE_DIM * `INPUT_DIM;
    localparam int NK = `INPUT_DIM * `STATE_DIM;

    typedef enum logic [1:0] {idle, fetch, wait_release} state_t;

    state_t    state;
    addr_t     idx;
    coef_sel_t nxt_sel;
    addr_t     nxt_addr;
    // Request issued one cycle ago, its word is on coef_data now
    coef_req_t cap_q;

    // Flat index walks A, then B, then K
    always_comb begin
        if (idx < addr_t'(NA)) begin
            nxt_sel  = coef_a;
            nxt_addr = idx;
        end else if (idx < addr_t'(NA + NB)) begin
            nxt_sel  = coef_b;
            nxt_addr = idx - addr_t'(NA);
        end else begin
            nxt_sel  = coef_k;
            nxt_addr = idx - addr_t'(NA + NB);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= idle;
            idx     <= '0;
            coef_rd <= '0;
            cap_q   <= '0;
            run_go  <= 1'b0;
        end else begin
            coef_rd.valid <= 1'b0;
            cap_q         <= coef_rd;
            // Last K word lands this cycle
            run_go <= cap_q.valid && (cap_q.sel == coef_k) && (cap_q.addr == addr_t'(NK - 1));
            case (state)
                idle: begin
                    if (start) begin
                        state <= fetch;
                        idx   <= '0;
                    end
                end
                fetch: begin
                    coef_rd.valid <= 1'b1;
                    coef_rd.sel   <= nxt_sel;
                    coef_rd.addr  <= nxt_addr;
                    idx           <= idx + addr_t'(1);
                    if (idx == addr_t'(NA + NB + NK - 1)) begin
                        state <= wait_release;
                    end
                end
                // Host keeps start high for the whole run
                wait_release: begin
                    if (!start) begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cap_q.valid) begin
            case (cap_q.sel)
                coef_a:  a_bank[cap_q.addr] <= coef_data;
                coef_b:  b_bank[cap_q.addr] <= coef_data;
                default: k_bank[cap_q.addr] <= coef_data;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hw/control_law.sv ====
// Control law stage, u[k] = -K x[k] - d[k]

`timescale 1ns/100ps
`default_nettype none
`include "rollout_consts.svh"

module control_law (
    input  logic                                               clk,
    input  logic                                               rst,
    input  logic                                               run_go,
    input  rollout_num_pkg::data_t [`STATE_DIM-1:0]            x_init,
    input  rollout_num_pkg::step_t                             active_horizon,
    input  rollout_num_pkg::data_t [`INPUT_DIM*`STATE_DIM-1:0] k_bank,
    output rollout_bus_pkg::rd_req_t                           d_rd,
    input  rollout_num_pkg::data_t                             d_data,
    input  rollout_num_pkg::data_t [`STATE_DIM-1:0]            x_next,
    input  logic                                               x_next_valid,
    output logic                                               u_go,
    output rollout_num_pkg::step_t                             k_out,
    output rollout_num_pkg::data_t [`STATE_DIM-1:0]            x_out,
    output rollout_num_pkg::data_t [`INPUT_DIM-1:0]            u_out,
    output logic                                               last
);
    import rollout_num_pkg::*;

    typedef enum logic [1:0] {idle, mac, sub} state_t;

    state_t                 state;
    elem_t                  i;
    elem_t                  j;
    step_t                  k;
    data_t                  acc;
    data_t                  d_q;
    data_t [`STATE_DIM-1:0] x_q;
    data_t [`INPUT_DIM-1:0] u_q;
    logic                   begin_run;
    logic                   begin_next;

    assign begin_run  = (state == idle) && run_go;
    // Next step starts when x[k+1] returns, unless k was the final step
    assign begin_next = (state == idle) && x_next_valid && !last;
    assign last       = (k + step_t'(1)) == active_horizon;

    // d[k][i] requested in the first MAC cycle of row i
    assign d_rd.valid = (state == mac) && (j == '0);
    assign d_rd.addr  = addr_t'(k * `INPUT_DIM + i);

    assign k_out = k;
    assign x_out = x_q;
    assign u_out = u_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= idle;
            i     <= '0;
            j     <= '0;
            k     <= '0;
            u_go  <= 1'b0;
        end else begin
            u_go <= 1'b0;
            case (state)
                idle: begin
                    if (begin_run || begin_next) begin
                        state <= mac;
                        i     <= '0;
                        j     <= '0;
                        k     <= begin_run ? '0 : k + step_t'(1);
                    end
                end
                mac: begin
                    if (j == elem_t'(`STATE_DIM - 1)) begin
                        state <= sub;
                    end else begin
                        j <= j + elem_t'(1);
                    end
                end
                sub: begin
                    j <= '0;
                    if (i == elem_t'(`INPUT_DIM - 1)) begin
                        state <= idle;
                        u_go  <= 1'b1;
                    end else begin
                        state <= mac;
                        i     <= i + elem_t'(1);
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (begin_run) begin
            x_q <= x_init;
        end else if (begin_next) begin
            x_q <= x_next;
        end
        if (state == mac) begin
            acc <= acc + k_bank[i * `STATE_DIM + j] * x_q[j];
        end else begin
            acc <= '0;
        end
        // Read data arrives one cycle after the request
        if ((state == mac) && (j == elem_t'(1))) begin
            d_q <= d_data;
        end
        if (state == sub) begin
            u_q[i] <= -acc - d_q;
        end
    end

endmodule

`default_nettype wire

// ==== hw/rollout_bus_pkg.sv ====
// Request, write and step structs

`default_nettype none
`include "rollout_consts.svh"

package rollout_bus_pkg;

    typedef struct packed {
        logic                       valid;
        rollout_num_pkg::coef_sel_t sel;
        rollout_num_pkg::addr_t     addr;
    } coef_req_t;

    typedef struct packed {
        logic                   valid;
        rollout_num_pkg::addr_t addr;
    } rd_req_t;

    typedef struct packed {
        logic                   wren;
        rollout_num_pkg::addr_t addr;
        rollout_num_pkg::data_t data;
    } wr_port_t;

    // One finished step, x[k] and u[k] together
    typedef struct packed {
        logic                                     valid;
        rollout_num_pkg::step_t                   k;
        logic                                     last;
        rollout_num_pkg::data_t [`STATE_DIM-1:0]  x;
        rollout_num_pkg::data_t [`INPUT_DIM-1:0]  u;
    } step_item_t;

endpackage

`default_nettype wire

// ==== hw/rollout_consts.svh ====
// Rollout dimensions and widths

`ifndef ROLLOUT_CONSTS_SVH
`define ROLLOUT_CONSTS_SVH

// Number of state elements (nx)
`define STATE_DIM 6

// Number of control inputs (nu)
`define INPUT_DIM 3

// Largest allowed active_horizon
`define HORIZON_MAX 30

`define DATA_WIDTH 32
`define ADDR_WIDTH 9

`endif

// ==== hw/rollout_num_pkg.sv ====
// Numeric types of the rollout

`default_nettype none
`include "rollout_consts.svh"

package rollout_num_pkg;

    // One matrix or vector element, two's complement
    typedef logic [`DATA_WIDTH-1:0] data_t;

    // Word address into the coefficient, d, x and u memories
    typedef logic [`ADDR_WIDTH-1:0] addr_t;

    // Step index k, covers HORIZON_MAX
    typedef logic [4:0] step_t;

    // Row or column index within a matrix
    typedef logic [2:0] elem_t;

    // Matrix behind the shared coefficient port
    typedef enum logic [1:0] {
        coef_a,
        coef_b,
        coef_k
    } coef_sel_t;

endpackage

`default_nettype wire

// ==== hw/rollout_top.sv ====
// MPC forward rollout top level

`timescale 1ns/100ps
`default_nettype none
`include "rollout_consts.svh"

module rollout_top (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    start,
    input  rollout_num_pkg::step_t                  active_horizon,
    input  rollout_num_pkg::data_t [`STATE_DIM-1:0] x_init,
    output rollout_bus_pkg::coef_req_t              coef_rd,
    input  rollout_num_pkg::data_t                  coef_data,
    output rollout_bus_pkg::rd_req_t                d_rd,
    input  rollout_num_pkg::data_t                  d_data,
    output rollout_bus_pkg::wr_port_t               x_wr,
    output rollout_bus_pkg::wr_port_t               u_wr,
    output logic                                    done
);
    import rollout_num_pkg::*;
    import rollout_bus_pkg::*;

    data_t [`STATE_DIM*`STATE_DIM-1:0] a_bank;
    data_t [`STATE_DIM*`INPUT_DIM-1:0] b_bank;
    data_t [`INPUT_DIM*`STATE_DIM-1:0] k_bank;
    logic                              run_go;
    logic                              u_go;
    step_t                             k_cur;
    data_t [`STATE_DIM-1:0]            x_cur;
    data_t [`INPUT_DIM-1:0]            u_cur;
    logic                              last_cur;
    data_t [`STATE_DIM-1:0]            x_next;
    logic                              x_next_valid;
    step_item_t                        step_item;

    coef_loader coef_loader_i (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .coef_rd   (coef_rd),
        .coef_data (coef_data),
        .a_bank    (a_bank),
        .b_bank    (b_bank),
        .k_bank    (k_bank),
        .run_go    (run_go)
    );

    // Control law and state update hand steps back and forth
    control_law control_law_i (
        .clk            (clk),
        .rst            (rst),
        .run_go         (run_go),
        .x_init         (x_init),
        .active_horizon (active_horizon),
        .k_bank         (k_bank),
        .d_rd           (d_rd),
        .d_data         (d_data),
        .x_next         (x_next),
        .x_next_valid   (x_next_valid),
        .u_go           (u_go),
        .k_out          (k_cur),
        .x_out          (x_cur),
        .u_out          (u_cur),
        .last           (last_cur)
    );

    state_update state_update_i (
        .clk          (clk),
        .rst          (rst),
        .u_go         (u_go),
        .k_in         (k_cur),
        .x_in         (x_cur),
        .u_in         (u_cur),
        .last_in      (last_cur),
        .a_bank       (a_bank),
        .b_bank       (b_bank),
        .x_next       (x_next),
        .x_next_valid (x_next_valid),
        .step_item    (step_item)
    );

    trajectory_writer trajectory_writer_i (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .step_item (step_item),
        .x_wr      (x_wr),
        .u_wr      (u_wr),
        .done      (done)
    );

endmodule

`default_nettype wire

// ==== hw/state_update.sv ====
// State update stage, x[k+1] = A x[k] + B u[k]

`timescale 1ns/100ps
`default_nettype none
`include "rollout_consts.svh"

module state_update (
    input  logic                                               clk,
    input  logic                                               rst,
    input  logic                                               u_go,
    input  rollout_num_pkg::step_t                             k_in,
    input  rollout_num_pkg::data_t [`STATE_DIM-1:0]            x_in,
    input  rollout_num_pkg::data_t [`INPUT_DIM-1:0]            u_in,
    input  logic                                               last_in,
    input  rollout_num_pkg::data_t [`STATE_DIM*`STATE_DIM-1:0] a_bank,
    input  rollout_num_pkg::data_t [`STATE_DIM*`INPUT_DIM-1:0] b_bank,
    output rollout_num_pkg::data_t [`STATE_DIM-1:0]            x_next,
    output logic                                               x_next_valid,
    output rollout_bus_pkg::step_item_t                        step_item
);
    import rollout_num_pkg::*;

    localparam int NT = `STATE_DIM + `INPUT_DIM;

    logic                   busy;
    elem_t                  r;
    logic [3:0]             t;
    step_t                  k_q;
    logic                   last_q;
    data_t [`STATE_DIM-1:0] x_q;
    data_t [`INPUT_DIM-1:0] u_q;
    data_t                  acc;
    data_t                  term;

    // Row r terms, nx from A x then nu from B u
    always_comb begin
        if (t < 4'(`STATE_DIM)) begin
            term = a_bank[r * `STATE_DIM + t] * x_q[t];
        end else begin
            term = b_bank[r * `INPUT_DIM + (t - 4'(`STATE_DIM))] * u_q[t - 4'(`STATE_DIM)];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy         <= 1'b0;
            r            <= '0;
            t            <= '0;
            x_next_valid <= 1'b0;
        end else begin
            x_next_valid <= 1'b0;
            if (u_go) begin
                busy <= 1'b1;
                r    <= '0;
                t    <= '0;
            end else if (busy) begin
                if (t == 4'(NT - 1)) begin
                    t <= '0;
                    if (r == elem_t'(`STATE_DIM - 1)) begin
                        busy         <= 1'b0;
                        x_next_valid <= 1'b1;
                    end else begin
                        r <= r + elem_t'(1);
                    end
                end else begin
                    t <= t + 4'(1);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (u_go) begin
            k_q    <= k_in;
            x_q    <= x_in;
            u_q    <= u_in;
            last_q <= last_in;
        end
        if (busy && (t == 4'(NT - 1))) begin
            x_next[r] <= acc + term;
            acc       <= '0;
        end else if (busy) begin
            acc <= acc + term;
        end else begin
            acc <= '0;
        end
    end

    // Step k leaves together with x[k+1]
    assign step_item = '{valid: x_next_valid, k: k_q, last: last_q, x: x_q, u: u_q};

endmodule

`default_nettype wire

// ==== hw/trajectory_writer.sv ====
// Trajectory writer for x and u

`timescale 1ns/100ps
`default_nettype none
`include "rollout_consts.svh"

module trajectory_writer (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        start,
    input  rollout_bus_pkg::step_item_t step_item,
    output rollout_bus_pkg::wr_port_t   x_wr,
    output rollout_bus_pkg::wr_port_t   u_wr,
    output logic                        done
);
    import rollout_num_pkg::*;
    import rollout_bus_pkg::*;

    localparam int NW = `STATE_DIM + `INPUT_DIM;

    step_item_t item_q;
    logic       busy;
    // Word index, x words first then u words
    logic [3:0] w;

    always_ff @(posedge clk) begin
        if (step_item.valid) begin
            item_q <= step_item;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy <= 1'b0;
            w    <= '0;
            x_wr <= '0;
            u_wr <= '0;
            done <= 1'b0;
        end else begin
            x_wr.wren <= 1'b0;
            u_wr.wren <= 1'b0;
            if (step_item.valid) begin
                busy <= 1'b1;
                w    <= '0;
            end else if (busy) begin
                if (w < 4'(`STATE_DIM)) begin
                    x_wr.wren <= 1'b1;
                    x_wr.addr <= addr_t'(item_q.k * `STATE_DIM + w);
                    x_wr.data <= item_q.x[w];
                end else begin
                    u_wr.wren <= 1'b1;
                    u_wr.addr <= addr_t'(item_q.k * `INPUT_DIM + (w - 4'(`STATE_DIM)));
                    u_wr.data <= item_q.u[w - 4'(`STATE_DIM)];
                end
                if (w == 4'(NW - 1)) begin
                    busy <= 1'b0;
                end else begin
                    w <= w + 4'(1);
                end
            end
            // Raised once the last step's final u word is out
            if (!start) begin
                done <= 1'b0;
            end else if (u_wr.wren && !busy && item_q.last) begin
                done <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build and run the rollout testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f compile.f --top-module rollout_tb \
    -Mdir obj_dir -o rollout_sim &&
./obj_dir/rollout_sim | tee /dev/stderr | grep -F "*** TEST PASSED ***" > /dev/null &&
echo "Simulation run succeeded" ||
{ echo "Simulation run did not succeed"; exit 1; }
